// File: hw/access_decode.sv
`include "lsu_macros.svh"

module access_decode (
	input logic req,
	input lsu_data_pkg::word_t addr,
	input logic we,
	input lsu_access_pkg::mode_t mode,
	input lsu_data_pkg::word_t wdata,
	lsu_access_if.decode acc
);

	import lsu_data_pkg::*;
	import lsu_access_pkg::*;

	logic in_window; // Address inside the data window.
	logic aligned; // Address meets the mode's alignment.
	logic legal; // Access may proceed.
	byte_offset_t offset; // Low address bits.
	byte_mask_t store_mask; // Lanes written by this access.
	word_t placed; // Store data replicated over its lanes.

	assign offset = addr[1:0];

	// Window and alignment rules.
	always_comb begin
		in_window = (addr >= `LSU_ADDR_LB) && (addr <= `LSU_ADDR_UB);
		case (mode)
			`LSU_MODE_W: aligned = (offset == 2'b00); // Word boundary.
			`LSU_MODE_H, `LSU_MODE_HU: aligned = ~offset[0]; // Halfword boundary.
			`LSU_MODE_B, `LSU_MODE_BU: aligned = 1'b1; // Any byte.
			default: aligned = 1'b0; // Unused codes fault.
		endcase
	end

	assign legal = (mode == `LSU_MODE_NONE) || (in_window && aligned); // NONE never faults.

	// Lane mask, only for a legal store that is really issued.
	always_comb begin
		store_mask = '0;
		if (req && we && legal) begin
			case (mode)
				`LSU_MODE_W: store_mask = 4'b1111; // All lanes.
				`LSU_MODE_H: store_mask = offset[1] ? 4'b1100 : 4'b0011; // Upper or lower half.
				`LSU_MODE_B: store_mask = byte_mask_t'(4'b0001 << offset); // Single lane.
				default: store_mask = '0; // HU, BU and NONE stores write nothing.
			endcase
		end
	end

	// Put the halfword or byte on every lane it may land on,
	// the mask then picks the right one.
	always_comb begin
		case (mode)
			`LSU_MODE_H, `LSU_MODE_HU: placed = {2{wdata[15:0]}};
			`LSU_MODE_B, `LSU_MODE_BU: placed = {4{wdata[7:0]}};
			default: placed = wdata; // Word goes as is.
		endcase
	end

	assign acc.strobe = req;
	assign acc.ok = legal;
	// Stores return zero, so the result side sees them as NONE.
	assign acc.mode = we ? mode_t'(`LSU_MODE_NONE) : mode;
	assign acc.offset = offset;
	assign acc.index = addr[`LSU_INDEX_BITS+1:2]; // Word address in the window.
	assign acc.mask = store_mask;
	assign acc.wdata = placed;

endmodule

// File: hw/byte_lane_ram.sv
`include "lsu_macros.svh"

module byte_lane_ram (
	input logic clk,
	lsu_access_if.bank acc,
	output lsu_data_pkg::word_t rword
);

	import lsu_data_pkg::*;

	word_t mem [0:`LSU_MEM_WORDS-1]; // Data storage, contents undefined after reset.
	logic write_en; // Legal access issued this cycle.

	assign write_en = acc.strobe && acc.ok;

	// Per-lane write, only masked bytes change.
	always_ff @(posedge clk) begin
		if (write_en) begin
			for (int lane = 0; lane < 4; lane++) begin
				if (acc.mask[lane]) begin
					mem[acc.index][lane*8 +: 8] <= acc.wdata[lane*8 +: 8];
				end
			end
		end
	end

	// Read port, old contents at a same-edge write.
	always_ff @(posedge clk) begin
		if (acc.strobe) begin
			rword <= mem[acc.index]; // Held until the next access.
		end
	end

endmodule

// File: hw/load_align.sv
`include "lsu_macros.svh"

module load_align (
	input logic clk,
	input logic reset,
	lsu_access_if.result acc,
	input lsu_data_pkg::word_t rword,
	output logic resp,
	output logic fault,
	output lsu_data_pkg::word_t rdata
);

	import lsu_data_pkg::*;
	import lsu_access_pkg::*;

	logic strobe_q; // Access pending a response.
	logic ok_q; // Pending access was legal.
	logic load_q; // Pending access returns data.
	mode_t mode_q; // Pending access mode.
	byte_offset_t offset_q; // Pending byte position.
	logic [15:0] half; // Addressed halfword.
	logic [7:0] lane; // Addressed byte.
	word_t ext; // Extended load value.

	// Response strobe, the only control state here.
	always_ff @(posedge clk) begin
		if (reset) begin
			strobe_q <= 1'b0;
		end else begin
			strobe_q <= acc.strobe; // One cycle behind req.
		end
	end

	// Access description, captured with the RAM read.
	always_ff @(posedge clk) begin
		if (acc.strobe) begin
			ok_q <= acc.ok;
			load_q <= (acc.mode != `LSU_MODE_NONE); // Stores arrive as NONE.
			mode_q <= acc.mode;
			offset_q <= acc.offset;
		end
	end

	// Pick and extend the addressed part of the word.
	always_comb begin
		half = offset_q[1] ? rword[31:16] : rword[15:0];
		lane = rword[{offset_q, 3'b000} +: 8];
		case (mode_q)
			`LSU_MODE_W: ext = rword;
			`LSU_MODE_H: ext = {{16{half[15]}}, half}; // Sign extend.
			`LSU_MODE_HU: ext = {16'h0000, half}; // Zero extend.
			`LSU_MODE_B: ext = {{24{lane[7]}}, lane};
			`LSU_MODE_BU: ext = {24'h00_0000, lane};
			default: ext = '0;
		endcase
	end

	assign resp = strobe_q;
	assign fault = strobe_q && !ok_q; // Checks failed.
	assign rdata = (ok_q && load_q) ? ext : '0; // Zero for stores, NONE and faults.

endmodule

// File: hw/lsu_access_if.sv
interface lsu_access_if;

	import lsu_data_pkg::*;
	import lsu_access_pkg::*;

	logic strobe; // Access issued this cycle.
	logic ok; // Passed window and alignment checks.
	mode_t mode; // Mode seen by the result side.
	byte_offset_t offset; // Byte position in the word.
	word_index_t index; // RAM word index.
	byte_mask_t mask; // Lanes to write.
	word_t wdata; // Store data placed on its lanes.

	// Decoder drives the whole description.
	modport decode (
		output strobe, ok, mode, offset, index, mask, wdata
	);

	// RAM bank needs only the write and read side.
	modport bank (
		input strobe, ok, index, mask, wdata
	);

	// Result stage needs what shapes the load value.
	modport result (
		input strobe, ok, mode, offset
	);

endinterface

// File: hw/lsu_access_pkg.sv
package lsu_access_pkg;

	// Access mode, see the LSU_MODE_* codes.
	typedef logic [2:0] mode_t;

	// Byte position inside a word.
	typedef logic [1:0] byte_offset_t;

endpackage

// File: hw/lsu_data_pkg.sv
`include "lsu_macros.svh"

package lsu_data_pkg;

	// Data word, also used for a byte address.
	typedef logic [31:0] word_t;

	// Word index into the data RAM.
	typedef logic [`LSU_INDEX_BITS-1:0] word_index_t;

	// One write enable per byte lane, bit 0 is bits 7 to 0.
	typedef logic [3:0] byte_mask_t;

endpackage

// File: hw/lsu_top.sv
module lsu_top (
	input logic clk,
	input logic reset,
	input logic req,
	input lsu_data_pkg::word_t addr,
	input logic we,
	input lsu_access_pkg::mode_t mode,
	input lsu_data_pkg::word_t wdata,
	output logic resp,
	output logic fault,
	output lsu_data_pkg::word_t rdata
);

	lsu_data_pkg::word_t rword; // RAM read word to the result stage.

	lsu_access_if acc (); // Decoded access.

	// Address check, lane mask and store placement.
	access_decode decode0 (
		.req (req),
		.addr (addr),
		.we (we),
		.mode (mode),
		.wdata (wdata),
		.acc (acc.decode)
	);

	// Byte-lane data RAM.
	byte_lane_ram bank0 (
		.clk (clk),
		.acc (acc.bank),
		.rword (rword)
	);

	// Load extension and response.
	load_align result0 (
		.clk (clk),
		.reset (reset),
		.acc (acc.result),
		.rword (rword),
		.resp (resp),
		.fault (fault),
		.rdata (rdata)
	);

endmodule

// File: include/lsu_macros.svh
`ifndef LSU_MACROS_SVH
`define LSU_MACROS_SVH

// Data RAM geometry.
`define LSU_MEM_WORDS 1024 // Words in the data RAM.
`define LSU_INDEX_BITS 10 // Word index width, log2 of the depth.

// Legal byte address window, inclusive at both ends.
`define LSU_ADDR_LB 32'h0000_0000 // Lowest data byte.
`define LSU_ADDR_UB 32'h0000_0FFF // Highest data byte.

// Access mode codes as issued by the pipeline.
`define LSU_MODE_NONE 3'd0 // No memory access.
`define LSU_MODE_W 3'd1 // Word.
`define LSU_MODE_H 3'd2 // Halfword, sign extended.
`define LSU_MODE_HU 3'd3 // Halfword, zero extended.
`define LSU_MODE_B 3'd4 // Byte, sign extended.
`define LSU_MODE_BU 3'd5 // Byte, zero extended.

// Codes 6 and 7 are unused and always fault.

`endif

// File: run_sim.sh
#!/usr/bin/env bash
# Build the LSU testbench with Verilator, run it, and judge the run from its log.

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --assert --timing --timescale 1ns/1ps \
	-f sources.f --top-module lsu_tb -o lsu_sim \
	&& ./obj_dir/lsu_sim +verilator+error+limit+1000 > sim.log 2>&1 \
	|| echo "simulation build or run failed"

cat sim.log 2> /dev/null

grep -q "^PASS: all tests$" sim.log 2> /dev/null \
	&& echo "run passed" \
	|| { echo "run failed"; exit 1; }

// File: sources.f
+incdir+include
hw/lsu_data_pkg.sv
hw/lsu_access_pkg.sv
hw/lsu_access_if.sv
hw/access_decode.sv
hw/byte_lane_ram.sv
hw/load_align.sv
hw/lsu_top.sv
test/lsu_assert.sv
test/lsu_tb.sv

// File: test/lsu_assert.sv
`include "lsu_macros.svh"

module lsu_assert (
	input logic clk,
	input logic reset,
	input logic req,
	input lsu_data_pkg::word_t addr,
	input logic we,
	input lsu_access_pkg::mode_t mode,
	input lsu_data_pkg::word_t wdata,
	input logic resp,
	input logic fault,
	input lsu_data_pkg::word_t rdata
);

	timeunit 1ns;
	timeprecision 1ps;

	import lsu_data_pkg::*;
	import lsu_access_pkg::*;

	logic [7:0] shadow [0:4*`LSU_MEM_WORDS-1]; // Byte image of the data RAM.
	logic written [0:4*`LSU_MEM_WORDS-1]; // Byte holds stored data.
	logic exp_valid; // Response due this cycle.
	logic exp_fault; // Expected fault of the pending access.
	logic exp_known; // Expected rdata is defined.
	word_t exp_rdata; // Expected load value.
	logic [5:0] reached; // Behavior n+1 exercised in bit n.
	int fail_count = 0; // Failed assertions.

	int nbytes; // Bytes the mode addresses.
	logic legal; // Window and alignment rules met.
	logic known; // All addressed bytes were written.
	word_t raw; // Addressed bytes, low aligned.
	word_t load_val; // Extended load value.

	// Expected outcome of the access on the inputs now.
	always_comb begin
		case (mode)
			`LSU_MODE_W: nbytes = 4;
			`LSU_MODE_H, `LSU_MODE_HU: nbytes = 2;
			`LSU_MODE_B, `LSU_MODE_BU: nbytes = 1;
			default: nbytes = 0; // NONE and unused codes.
		endcase
		legal = (mode == `LSU_MODE_NONE) || ((nbytes != 0) && (addr >= `LSU_ADDR_LB) &&
			(addr <= `LSU_ADDR_UB) && ((addr[1:0] & 2'(nbytes - 1)) == 2'b00));
		raw = '0;
		known = 1'b1;
		for (int i = 0; i < 4; i++) begin
			if (i < nbytes) begin
				raw[i*8 +: 8] = shadow[addr[11:0] + 12'(i)]; // Little endian.
				known = known & written[addr[11:0] + 12'(i)];
			end
		end
		case (mode)
			`LSU_MODE_H: load_val = {{16{raw[15]}}, raw[15:0]};
			`LSU_MODE_B: load_val = {{24{raw[7]}}, raw[7:0]};
			default: load_val = raw; // W, HU and BU are already zero filled.
		endcase
	end

	// Shadow memory and the one-deep pending record.
	always @(posedge clk) begin
		if (reset) begin
			exp_valid <= 1'b0;
			reached <= '0;
			for (int i = 0; i < 4*`LSU_MEM_WORDS; i++) begin
				written[i] <= 1'b0; // RAM holds nothing known.
			end
		end else begin
			exp_valid <= req;
			if (req) begin
				exp_fault <= !legal;
				exp_rdata <= (legal && !we) ? load_val : '0;
				exp_known <= we || !legal || known;
				if (legal && we && (mode == `LSU_MODE_W || mode == `LSU_MODE_H ||
					mode == `LSU_MODE_B)) begin
					for (int i = 0; i < nbytes; i++) begin
						shadow[addr[11:0] + 12'(i)] <= wdata[i*8 +: 8];
						written[addr[11:0] + 12'(i)] <= 1'b1;
					end
				end
				if (legal && !we && known) begin
					if (mode == `LSU_MODE_W && exp_valid) reached[0] <= 1'b1; // Back to back.
					if (mode == `LSU_MODE_H || mode == `LSU_MODE_HU) reached[1] <= 1'b1;
					if (mode == `LSU_MODE_B || mode == `LSU_MODE_BU) reached[2] <= 1'b1;
				end
				if (!legal) reached[3] <= 1'b1;
				if (mode == `LSU_MODE_NONE ||
					(legal && we && (mode == `LSU_MODE_HU || mode == `LSU_MODE_BU))) begin
					reached[4] <= 1'b1;
				end
			end
			if (exp_valid && !req) reached[5] <= 1'b1; // Response must drop next cycle.
		end
	end

	// Exactly one response in the cycle after each request.
	resp_follows_req: assert property (@(posedge clk) disable iff (reset) resp == exp_valid)
		else begin
			$error("mismatch at %0t: resp %b, expected %b", $time, resp, exp_valid);
			fail_count++;
		end

	fault_matches: assert property (@(posedge clk) disable iff (reset)
		exp_valid |-> fault == exp_fault)
		else begin
			$error("mismatch at %0t: fault %b, expected %b", $time, fault, exp_fault);
			fail_count++;
		end

	// Unwritten bytes have no defined value.
	rdata_matches: assert property (@(posedge clk) disable iff (reset)
		exp_valid && exp_known |-> rdata == exp_rdata)
		else begin
			$error("mismatch at %0t: rdata %h, expected %h", $time, rdata, exp_rdata);
			fail_count++;
		end

endmodule

// File: test/lsu_tb.sv
`include "lsu_macros.svh"

module lsu_tb;

	timeunit 1ns;
	timeprecision 1ps;

	import lsu_data_pkg::*;
	import lsu_access_pkg::*;

	localparam int cycle_limit = 1000; // Both phases take about 470 cycles.
	localparam int behaviors = 6;

	logic clk;
	logic reset;
	logic req;
	word_t addr;
	logic we;
	mode_t mode;
	word_t wdata;
	logic resp;
	logic fault;
	word_t rdata;

	integer seed = 32'hfae7_b702; // Random phase seed.
	int cycles = 0; // Cycles since start.
	int timeouts = 0;
	int unreached = 0; // Behaviors never exercised.

	lsu_top dut0 (
		.clk (clk),
		.reset (reset),
		.req (req),
		.addr (addr),
		.we (we),
		.mode (mode),
		.wdata (wdata),
		.resp (resp),
		.fault (fault),
		.rdata (rdata)
	);

	bind lsu_top lsu_assert chk0 (.*); // Checker sees the top level ports.

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk; // 100 ns period.
	end

	// Pattern from the whole address.
	function automatic word_t fill_word(input word_t a);
		word_t h;
		h = a ^ (a << 13) ^ 32'h9e37_79b9;
		return h ^ (h >> 7);
	endfunction

	// One access, driven just after the edge.
	task automatic issue(input logic store, input mode_t m, input word_t a, input word_t d);
		@(posedge clk);
		#10;
		req = 1'b1;
		we = store;
		mode = m;
		addr = a;
		wdata = d;
	endtask

	task automatic idle(input int n);
		repeat (n) begin
			@(posedge clk);
			#10;
			req = 1'b0;
		end
	endtask

	task automatic directed_accesses();
		word_t a;
		word_t d;
		for (int w = 0; w < 8; w++) begin
			a = word_t'(w * 4);
			issue(1'b1, `LSU_MODE_W, a, fill_word(a)); // Store then load, back to back.
			issue(1'b0, `LSU_MODE_W, a, '0);
		end
		idle(2); // Response must drop.
		for (int w = 8; w < 12; w++) begin
			a = word_t'(w * 4);
			d = fill_word(a ^ 32'h0000_5000);
			issue(1'b1, `LSU_MODE_W, a, fill_word(a));
			issue(1'b1, `LSU_MODE_H, a + word_t'((w % 2) * 2), (w < 10) ? d : ~d); // One half only.
			for (int off = 0; off < 4; off += 2) begin
				issue(1'b0, `LSU_MODE_H, a + word_t'(off), '0);
				issue(1'b0, `LSU_MODE_HU, a + word_t'(off), '0);
			end
			issue(1'b0, `LSU_MODE_W, a, '0);
		end
		for (int w = 12; w < 16; w++) begin
			a = word_t'(w * 4);
			d = fill_word(a ^ 32'h0000_a000);
			issue(1'b1, `LSU_MODE_W, a, fill_word(a));
			issue(1'b1, `LSU_MODE_B, a + word_t'(w - 12), d); // Lane w-12.
			for (int lane = 0; lane < 4; lane++) begin
				issue(1'b0, `LSU_MODE_B, a + word_t'(lane), '0);
				issue(1'b0, `LSU_MODE_BU, a + word_t'(lane), '0);
			end
			issue(1'b0, `LSU_MODE_W, a, '0);
		end
		// Top of the window.
		issue(1'b1, `LSU_MODE_W, 32'h0000_0ffc, fill_word(32'h0000_0ffc));
		issue(1'b1, `LSU_MODE_B, 32'h0000_0fff, 32'h0000_0080);
		issue(1'b0, `LSU_MODE_BU, 32'h0000_0fff, '0);
		issue(1'b0, `LSU_MODE_H, 32'h0000_0ffe, '0);
		issue(1'b0, `LSU_MODE_W, 32'h0000_0ffc, '0);
		idle(1);
		// Faults.
		issue(1'b0, `LSU_MODE_W, 32'h0000_0006, '0);
		issue(1'b1, `LSU_MODE_W, 32'h0000_0002, 32'hdead_beef);
		issue(1'b1, `LSU_MODE_H, 32'h0000_0005, 32'h0000_1234);
		issue(1'b0, `LSU_MODE_HU, 32'h0000_0003, '0);
		issue(1'b1, `LSU_MODE_W, 32'h0000_1000, 32'h5555_aaaa); // Aliases word 0.
		issue(1'b0, `LSU_MODE_B, 32'hffff_fff0, '0);
		issue(1'b0, 3'd6, 32'h0000_0010, '0); // Unused code.
		issue(1'b0, `LSU_MODE_W, 32'h0000_0000, '0);
		issue(1'b0, `LSU_MODE_W, 32'h0000_0004, '0);
		// Accesses that return zero without a fault.
		issue(1'b0, `LSU_MODE_NONE, 32'h0000_0020, '0);
		issue(1'b1, `LSU_MODE_NONE, 32'hffff_0001, 32'h1111_1111);
		issue(1'b1, `LSU_MODE_HU, 32'h0000_0020, 32'h2222_2222);
		issue(1'b1, `LSU_MODE_BU, 32'h0000_0021, 32'h3333_3333);
		issue(1'b0, `LSU_MODE_W, 32'h0000_0020, '0);
	endtask

	task automatic random_accesses();
		word_t r;
		word_t a;
		mode_t m;
		for (int n = 0; n < 300; n++) begin
			r = $random(seed);
			a = $random(seed);
			if (r[7:5] == 3'b000) idle(1);
			if (r[31:28] != 4'h0) a = {24'h00_0000, a[7:0]}; // First 64 words.
			if (r[3]) a[1:0] = 2'b00; // Bias toward aligned.
			m = mode_t'(r[2:0]);
			if (m > `LSU_MODE_BU && r[9:8] != 2'b00) m = `LSU_MODE_W;
			issue(r[4], m, a, $random(seed));
		end
	endtask

	task automatic finish_run();
		for (int b = 0; b < behaviors; b++) begin
			if (!dut0.chk0.reached[b]) begin
				$display("behavior %0d was never exercised", b + 1);
				unreached++;
			end
		end
		$display("errors: %0d assertion failures, %0d unreached behaviors, %0d timeouts",
			dut0.chk0.fail_count, unreached, timeouts);
		if (dut0.chk0.fail_count == 0 && unreached == 0 && timeouts == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	endtask

	always @(posedge clk) begin
		cycles++;
		if (cycles == cycle_limit) begin
			$display("timeout: run still busy after %0d cycles", cycle_limit);
			timeouts = 1;
			finish_run();
		end
	end

	initial begin
		reset = 1'b1;
		req = 1'b0;
		we = 1'b0;
		mode = `LSU_MODE_NONE;
		addr = '0;
		wdata = '0;
		repeat (3) @(posedge clk);
		#10;
		reset = 1'b0;
		idle(2);
		directed_accesses();
		idle(2);
		random_accesses();
		idle(2); // Last response checked.
		wait (resp == 1'b0);
		finish_run();
	end

endmodule
